/* Bender.yml */
package:
  name: ahb_output_stage

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/ahb_matrix_pkg.sv
      - design/port_mux.sv
      - design/output_arbiter.sv
      - design/data_phase_ctrl.sv
      - design/ahb_output_stage.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/tb_ahb_output_stage.sv

/* design/ahb_matrix_config.svh */
/*
 * Build-time constants for the AHB matrix output stage.
 * Port count, bus widths and the AHB HTRANS/HBURST encodings.
 * Include in any RTL or testbench file that needs them.
 */

`ifndef AHB_MATRIX_CONFIG_SVH
`define AHB_MATRIX_CONFIG_SVH

// Matrix geometry --------------------
`define NUM_PORTS      4       // Input stages sharing the target
`define PORT_W         2       // Bits to index a port
`define ADDR_W         32      // HADDR width
`define DATA_W         32      // HWDATA width

// HTRANS codes --------------------
`define HTRANS_IDLE    2'b00   // No transfer
`define HTRANS_BUSY    2'b01   // Burst pause
`define HTRANS_NONSEQ  2'b10   // First beat
`define HTRANS_SEQ     2'b11   // Burst continuation

// HBURST codes
`define HBURST_SINGLE  3'b000  // Single beat, no burst hold

`endif

/* design/ahb_matrix_pkg.sv */
/*
 * Shared types for the AHB matrix output stage.
 * Holds the port index, the write data word and the packed
 * address/control bundle carried through the control multiplexer.
 * Import with a wildcard in the module header.
 */

`include "ahb_matrix_config.svh"

package ahb_matrix_pkg;

  // Index types --------------------

  // Selects one input port
  typedef logic [`PORT_W-1:0] port_idx_t;

  // Payload types --------------------

  // One write data word
  typedef logic [`DATA_W-1:0] hdata_t;

  // Address phase fields of one port, MSB first
  typedef struct packed {
    logic              sel;       // HSEL towards the target
    logic [`ADDR_W-1:0] addr;     // HADDR
    logic [1:0]        trans;     // HTRANS
    logic              write;     // HWRITE
    logic [2:0]        size;      // HSIZE
    logic [2:0]        burst;     // HBURST
    logic              mastlock;  // HMASTLOCK
  } ahb_ctrl_t;

  // Note the struct width follows ADDR_W, so
  // a wider address bus needs no edits here

endpackage

/* design/ahb_output_stage.sv */
/*
 * Shared-target output stage of a four-port AHB bus matrix.
 * Arbitrates the held transfers of the input stages, passes the
 * granted port's address/control to the target, steers write data
 * in the data phase and returns ready to the input stages.
 */

`timescale 1ns/1ps

`include "ahb_matrix_config.svh"

module ahb_output_stage
  import ahb_matrix_pkg::*;
(
  input  logic                                HCLK,           // AHB clock
  input  logic                                HRESETn,        // Sync reset, active low

  // Input stage side --------------------
  input  logic [`NUM_PORTS-1:0]               i_sel_op,       // HSEL per port
  input  logic [`NUM_PORTS-1:0][`ADDR_W-1:0]  i_addr_op,      // HADDR per port
  input  logic [`NUM_PORTS-1:0][1:0]          i_trans_op,     // HTRANS per port
  input  logic [`NUM_PORTS-1:0]               i_write_op,     // HWRITE per port
  input  logic [`NUM_PORTS-1:0][2:0]          i_size_op,      // HSIZE per port
  input  logic [`NUM_PORTS-1:0][2:0]          i_burst_op,     // HBURST per port
  input  logic [`NUM_PORTS-1:0]               i_mastlock_op,  // HMASTLOCK per port
  input  logic [`NUM_PORTS-1:0][`DATA_W-1:0]  i_wdata_op,     // HWDATA per port
  input  logic [`NUM_PORTS-1:0]               i_held_tran_op, // Transfer waiting

  // Target side
  input  logic                                i_hreadyoutm,   // Target ready

  output logic [`NUM_PORTS-1:0]               o_active_op,    // One-hot grant
  output logic                                o_hselm,        // Target select
  output logic [`ADDR_W-1:0]                  o_haddrm,       // Address
  output logic [1:0]                          o_htransm,      // Transfer type
  output logic                                o_hwritem,      // Direction
  output logic [2:0]                          o_hsizem,       // Size
  output logic [2:0]                          o_hburstm,      // Burst type
  output logic                                o_hmastlockm,   // Locked transfer
  output logic                                o_hreadymuxm,   // Transfer done
  output logic [`DATA_W-1:0]                  o_hwdatam       // Write data
);

  // Internal signals --------------------

  logic [`NUM_PORTS-1:0] req;                   // Per-port request
  ahb_ctrl_t             ctrl_op [`NUM_PORTS];  // Packed control per port
  hdata_t                wdata_op [`NUM_PORTS]; // Write data per port
  ahb_ctrl_t             ctrl_m;                // Granted control bundle
  port_idx_t             addr_in_port;          // Address phase grant
  port_idx_t             data_in_port;          // Data phase owner
  logic                  no_port;               // Nothing granted
  logic                  wdata_phase;           // Write data steering on

  // Packing --------------------

  assign req = i_held_tran_op & i_sel_op;  // Held transfer aimed here

  for (genvar p = 0; p < `NUM_PORTS; p++)
  begin : g_pack
    assign ctrl_op[p].sel      = i_sel_op[p];
    assign ctrl_op[p].addr     = i_addr_op[p];
    assign ctrl_op[p].trans    = i_trans_op[p];
    assign ctrl_op[p].write    = i_write_op[p];
    assign ctrl_op[p].size     = i_size_op[p];
    assign ctrl_op[p].burst    = i_burst_op[p];
    assign ctrl_op[p].mastlock = i_mastlock_op[p];
    assign wdata_op[p]         = i_wdata_op[p];
  end

  // Arbitration --------------------

  output_arbiter u_output_arb (
    .HCLK           (HCLK),
    .HRESETn        (HRESETn),
    .i_req          (req),
    .i_hreadym      (o_hreadymuxm),
    .i_hselm        (ctrl_m.sel),
    .i_htransm      (ctrl_m.trans),
    .i_hburstm      (ctrl_m.burst),
    .i_hmastlockm   (ctrl_m.mastlock),
    .o_addr_in_port (addr_in_port),
    .o_no_port      (no_port)
  );

  // Decode grant to per-port active flags
  always_comb
  begin
    o_active_op = '0;
    if (!no_port)
      o_active_op[addr_in_port] = 1'b1;
  end

  // Address phase mux --------------------

  port_mux #(
    .payload_t (ahb_ctrl_t)
  ) u_ctrl_mux (
    .i_payload (ctrl_op),
    .i_sel     (addr_in_port),
    .i_valid   (~no_port),
    .o_payload (ctrl_m)
  );

  assign o_hselm      = ctrl_m.sel;
  assign o_haddrm     = ctrl_m.addr;
  assign o_htransm    = ctrl_m.trans;
  assign o_hwritem    = ctrl_m.write;
  assign o_hsizem     = ctrl_m.size;
  assign o_hburstm    = ctrl_m.burst;
  assign o_hmastlockm = ctrl_m.mastlock;

  // Data phase --------------------

  data_phase_ctrl u_data_ctrl (
    .HCLK           (HCLK),
    .HRESETn        (HRESETn),
    .i_addr_in_port (addr_in_port),
    .i_hselm        (ctrl_m.sel),
    .i_htransm      (ctrl_m.trans),
    .i_hreadyoutm   (i_hreadyoutm),
    .o_data_in_port (data_in_port),
    .o_wdata_phase  (wdata_phase),
    .o_hreadymuxm   (o_hreadymuxm)
  );

  // Write data held at zero outside a data phase
  port_mux #(
    .payload_t (hdata_t)
  ) u_data_mux (
    .i_payload (wdata_op),
    .i_sel     (data_in_port),
    .i_valid   (wdata_phase),
    .o_payload (o_hwdatam)
  );

endmodule

/* design/data_phase_ctrl.sv */
/*
 * Data phase control for the output stage.
 * Remembers which port owns the current data phase, whether write
 * data must be steered, and whether the target was selected, then
 * forms the ready returned to the input stages.
 */

`timescale 1ns/1ps

`include "ahb_matrix_config.svh"

module data_phase_ctrl
  import ahb_matrix_pkg::*;
(
  input  logic      HCLK,            // AHB clock
  input  logic      HRESETn,         // Sync reset, active low
  input  port_idx_t i_addr_in_port,  // Current address phase owner
  input  logic      i_hselm,         // Muxed HSEL
  input  logic [1:0] i_htransm,      // Muxed HTRANS
  input  logic      i_hreadyoutm,    // Ready from the target
  output port_idx_t o_data_in_port,  // Data phase owner
  output logic      o_wdata_phase,   // Steer write data this cycle
  output logic      o_hreadymuxm     // Ready back to the input stages
);

  // Internal signals --------------------

  logic slave_sel;     // Target took part in last address phase
  logic trans_active;  // NONSEQ or SEQ on the output

  assign trans_active = (i_htransm == `HTRANS_NONSEQ) ||
                        (i_htransm == `HTRANS_SEQ);

  // Data phase registers --------------------

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      o_data_in_port <= port_idx_t'(`NUM_PORTS - 1);
      o_wdata_phase  <= 1'b0;
      slave_sel      <= 1'b0;
    end
    else if (o_hreadymuxm)   // Address phase completes
    begin
      o_data_in_port <= i_addr_in_port;
      o_wdata_phase  <= i_hselm & trans_active;
      slave_sel      <= i_hselm;
    end
  end

  // Ready --------------------

  // Target drives ready only when it owns the data phase
  assign o_hreadymuxm = slave_sel ? i_hreadyoutm : 1'b1;

endmodule

/* design/output_arbiter.sv */
/*
 * Fixed-priority arbiter for the shared target of the output stage.
 * Port 0 has the highest priority. The grant is held through a
 * burst and through a locked sequence, also while the locked master
 * briefly deselects the target. All state advances on ready edges.
 */

`timescale 1ns/1ps

`include "ahb_matrix_config.svh"

module output_arbiter
  import ahb_matrix_pkg::*;
(
  input  logic                  HCLK,           // AHB clock
  input  logic                  HRESETn,        // Sync reset, active low
  input  logic [`NUM_PORTS-1:0] i_req,          // Held transfer and HSEL, per port
  input  logic                  i_hreadym,      // Muxed ready from the data phase
  input  logic                  i_hselm,        // Muxed HSEL of the granted port
  input  logic [1:0]            i_htransm,      // Muxed HTRANS
  input  logic [2:0]            i_hburstm,      // Muxed HBURST
  input  logic                  i_hmastlockm,   // Muxed HMASTLOCK
  output port_idx_t             o_addr_in_port, // Registered grant
  output logic                  o_no_port       // No port granted
);

  // Internal signals --------------------

  logic      hsel_lock;       // Locked sequence started on this target
  logic      next_hsel_lock;  // Pre-registered hsel_lock
  logic      hlock_arb;       // Mastlock masked by select
  logic      trans_active;    // NONSEQ or SEQ on the output
  logic      burst_hold;      // Granted port mid-burst
  logic      hold_grant;      // Keep current grant
  logic      any_req;         // At least one port asking
  port_idx_t pri_port;        // Lowest requesting index
  port_idx_t next_port;       // Grant for the next cycle
  logic      next_no_port;    // no_port for the next cycle

  // Lock tracking --------------------

  assign trans_active = (i_htransm == `HTRANS_NONSEQ) ||
                        (i_htransm == `HTRANS_SEQ);

  // Set on a selected locked beat, drop with mastlock
  always_comb
  begin
    if (i_hselm && trans_active && i_hmastlockm)
      next_hsel_lock = 1'b1;
    else if (!i_hmastlockm)
      next_hsel_lock = 1'b0;
    else
      next_hsel_lock = hsel_lock;  // Deselected but still locked
  end

  // Lock only counts once the sequence has reached this target
  assign hlock_arb = i_hmastlockm & (hsel_lock | i_hselm);

  // Priority select --------------------

  assign any_req = |i_req;

  // Walk down so the lowest index wins
  always_comb
  begin
    pri_port = o_addr_in_port;  // Old index kept when idle
    for (int i = `NUM_PORTS - 1; i >= 0; i--)
    begin
      if (i_req[i])
        pri_port = port_idx_t'(i);
    end
  end

  // Grant hold --------------------

  assign burst_hold = i_req[o_addr_in_port] & (i_hburstm != `HBURST_SINGLE);

  // A locked master may drop HSEL, and so its request, mid-sequence.
  // The lock alone then keeps the grant until mastlock falls.
  assign hold_grant = ~o_no_port & (hlock_arb | burst_hold);

  always_comb
  begin
    if (hold_grant)
    begin
      next_port    = o_addr_in_port;  // Stay with current owner
      next_no_port = 1'b0;
    end
    else
    begin
      next_port    = pri_port;        // Fresh arbitration
      next_no_port = ~any_req;        // Idle when nobody asks
    end
  end

  // Registers --------------------

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      o_addr_in_port <= port_idx_t'(`NUM_PORTS - 1);
      o_no_port      <= 1'b1;       // Nothing granted out of reset
      hsel_lock      <= 1'b0;
    end
    else if (i_hreadym)
    begin
      o_addr_in_port <= next_port;
      o_no_port      <= next_no_port;
      hsel_lock      <= next_hsel_lock;
    end
  end

endmodule

/* design/port_mux.sv */
/*
 * Port multiplexer for the output stage.
 * Returns the payload of the indexed input port, or an all-zero
 * payload when the select is not valid. The payload type is a
 * parameter so one block serves both address/control and write data.
 */

`timescale 1ns/1ps

`include "ahb_matrix_config.svh"

module port_mux
  import ahb_matrix_pkg::*;
#(
  parameter type payload_t = hdata_t  // Carried payload type
)
(
  input  payload_t  i_payload [`NUM_PORTS],  // One payload per port
  input  port_idx_t i_sel,                   // Port to pass through
  input  logic      i_valid,                 // Select is meaningful
  output payload_t  o_payload                // Chosen payload
);

  // Mux --------------------

  always_comb
  begin
    o_payload = '0;                        // Quiet bus by default
    if (i_valid)
    begin
      o_payload = i_payload[i_sel];        // Indexed port
    end
  end

endmodule

/* filelist.f */
+incdir+design
design/ahb_matrix_pkg.sv
design/port_mux.sv
design/output_arbiter.sv
design/data_phase_ctrl.sv
design/ahb_output_stage.sv
sim/tb_ahb_output_stage.sv

/* sim/tb_ahb_output_stage.sv */
/*
 * Testbench for the AHB matrix output stage.
 * A reference model tracks grant, lock and data phase state, and
 * concurrent assertions compare the DUT against it on every edge.
 * Directed tasks cover reset, pass-through, priority, burst hold,
 * locked sequences and write data with random wait states.
 */

`timescale 1ns/1ps

`include "ahb_matrix_config.svh"

module tb_ahb_output_stage
  import ahb_matrix_pkg::*;
;

  // Timing and budgets --------------------
  localparam int CLK_HALF     = 4;    // 8 ns period
  localparam int GRANT_WAIT   = 8;    // Cycles allowed for a grant
  localparam int MAX_WAITS    = 3;    // Target wait states per beat
  localparam int WRITE_BEATS  = 8;
  localparam int TEST_CYCLES  = 4 + (GRANT_WAIT + 5) + `NUM_PORTS * (GRANT_WAIT + 2) + 4
                              + 2 * (2 * GRANT_WAIT + 10)
                              + WRITE_BEATS * (GRANT_WAIT + MAX_WAITS + 3);
  localparam int WATCHDOG_NS  = (TEST_CYCLES + 20) * 2 * CLK_HALF;

  logic                              HCLK;
  logic                              HRESETn;
  logic [`NUM_PORTS-1:0]             sel_op;
  logic [`NUM_PORTS-1:0][`ADDR_W-1:0] addr_op;
  logic [`NUM_PORTS-1:0][1:0]        trans_op;
  logic [`NUM_PORTS-1:0]             write_op;
  logic [`NUM_PORTS-1:0][2:0]        size_op;
  logic [`NUM_PORTS-1:0][2:0]        burst_op;
  logic [`NUM_PORTS-1:0]             mastlock_op;
  logic [`NUM_PORTS-1:0][`DATA_W-1:0] wdata_op;
  logic [`NUM_PORTS-1:0]             held_op;
  logic                              i_hreadyoutm;
  logic [`NUM_PORTS-1:0]             o_active_op;
  logic                              o_hselm;
  logic [`ADDR_W-1:0]                o_haddrm;
  logic [1:0]                        o_htransm;
  logic                              o_hwritem;
  logic [2:0]                        o_hsizem;
  logic [2:0]                        o_hburstm;
  logic                              o_hmastlockm;
  logic                              o_hreadymuxm;
  logic [`DATA_W-1:0]                o_hwdatam;

  string cur_test = "reset_state";  // Named in every error line
  int    err_count = 0;
  int    err_start = 0;
  int    tests_run = 0;

  ahb_output_stage DUT (
    .HCLK           (HCLK),
    .HRESETn        (HRESETn),
    .i_sel_op       (sel_op),
    .i_addr_op      (addr_op),
    .i_trans_op     (trans_op),
    .i_write_op     (write_op),
    .i_size_op      (size_op),
    .i_burst_op     (burst_op),
    .i_mastlock_op  (mastlock_op),
    .i_wdata_op     (wdata_op),
    .i_held_tran_op (held_op),
    .i_hreadyoutm   (i_hreadyoutm),
    .o_active_op    (o_active_op),
    .o_hselm        (o_hselm),
    .o_haddrm       (o_haddrm),
    .o_htransm      (o_htransm),
    .o_hwritem      (o_hwritem),
    .o_hsizem       (o_hsizem),
    .o_hburstm      (o_hburstm),
    .o_hmastlockm   (o_hmastlockm),
    .o_hreadymuxm   (o_hreadymuxm),
    .o_hwdatam      (o_hwdatam)
  );

  initial
  begin
    HCLK = 1'b0;
    forever #(CLK_HALF) HCLK = ~HCLK;
  end

  // Reference model --------------------
  port_idx_t             m_grant;    // Address phase owner
  logic                  m_idle;     // Nobody granted
  logic                  m_lock;     // Locked sequence reached the target
  port_idx_t             m_dport;    // Data phase owner
  logic                  m_wphase;   // Write data due
  logic                  m_tsel;     // Target owns the data phase
  logic [`NUM_PORTS-1:0] m_req;
  logic                  m_busy;     // NONSEQ or SEQ at the output
  logic                  m_hold;
  int                    m_win;      // Lowest requester, -1 if none
  logic [`NUM_PORTS-1:0] exp_active;
  logic [42:0]           exp_ctrl;   // sel, addr, trans, write, size, burst, lock
  logic                  exp_ready;
  logic [`DATA_W-1:0]    exp_wdata;

  function automatic int lowest_request(input logic [`NUM_PORTS-1:0] req);
    int idx;
    idx = -1;
    for (int i = 0; i < `NUM_PORTS; i++)
    begin
      if (req[i] && idx < 0)
        idx = i;                   // First hit wins
    end
    return idx;
  endfunction

  always_comb
  begin
    exp_active = '0;
    exp_ctrl   = '0;
    if (!m_idle)
    begin
      exp_active[m_grant] = 1'b1;
      exp_ctrl = {sel_op[m_grant], addr_op[m_grant], trans_op[m_grant], write_op[m_grant],
                  size_op[m_grant], burst_op[m_grant], mastlock_op[m_grant]};
    end
    exp_ready = m_tsel ? i_hreadyoutm : 1'b1;
    exp_wdata = m_wphase ? wdata_op[m_dport] : '0;
    m_req     = held_op & sel_op;
    m_busy    = (exp_ctrl[9:8] == `HTRANS_NONSEQ) || (exp_ctrl[9:8] == `HTRANS_SEQ);
    m_hold    = !m_idle && ((exp_ctrl[0] && (m_lock || exp_ctrl[42])) ||
                            (m_req[m_grant] && exp_ctrl[3:1] != `HBURST_SINGLE));
    m_win     = lowest_request(m_req);
  end

  always @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      m_grant  <= port_idx_t'(`NUM_PORTS - 1);
      m_idle   <= 1'b1;
      m_lock   <= 1'b0;
      m_dport  <= port_idx_t'(`NUM_PORTS - 1);
      m_wphase <= 1'b0;
      m_tsel   <= 1'b0;
    end
    else if (exp_ready)                        // Only completed phases count
    begin
      if (!m_hold && m_win >= 0)
        m_grant <= port_idx_t'(m_win);
      m_idle   <= !m_hold && (m_win < 0);
      if (exp_ctrl[42] && m_busy && exp_ctrl[0])
        m_lock <= 1'b1;
      else if (!exp_ctrl[0])
        m_lock <= 1'b0;                        // Mastlock fell
      m_dport  <= m_grant;
      m_wphase <= exp_ctrl[42] && m_busy;
      m_tsel   <= exp_ctrl[42];
    end
  end

  // Reporting --------------------
  task automatic report_mismatch(input string what, input logic [63:0] exp,
                                 input logic [63:0] act);
    err_count++;
    $display("Fail %s (%s): expected 0x%0h actual 0x%0h", cur_test, what, exp, act);
  endtask

  task automatic report_problem(input string msg);
    err_count++;
    $display("Error in %s: %s", cur_test, msg);
  endtask

  // Checking --------------------
  assert property (@(posedge HCLK) disable iff (!HRESETn) o_active_op == exp_active)
    else report_mismatch("active", $sampled(exp_active), $sampled(o_active_op));

  assert property (@(posedge HCLK) disable iff (!HRESETn)
    {o_hselm, o_haddrm, o_htransm, o_hwritem, o_hsizem, o_hburstm, o_hmastlockm} == exp_ctrl)
    else report_mismatch("addr/ctrl", $sampled(exp_ctrl),
      $sampled({o_hselm, o_haddrm, o_htransm, o_hwritem, o_hsizem, o_hburstm, o_hmastlockm}));

  assert property (@(posedge HCLK) disable iff (!HRESETn) o_hreadymuxm == exp_ready)
    else report_mismatch("hready", $sampled(exp_ready), $sampled(o_hreadymuxm));

  assert property (@(posedge HCLK) disable iff (!HRESETn) o_hwdatam == exp_wdata)
    else report_mismatch("hwdata", $sampled(exp_wdata), $sampled(o_hwdatam));

  // Wait state must freeze the whole output side
  assert property (@(posedge HCLK) disable iff (!HRESETn)
    !o_hreadymuxm |=> $stable({o_active_op, o_hselm, o_haddrm, o_htransm, o_hwritem,
                               o_hsizem, o_hburstm, o_hmastlockm, o_hwdatam}))
    else report_problem("outputs changed during a wait state");

  // Stimulus helpers --------------------
  task automatic request_port(input int p, input logic [1:0] trans, input logic [2:0] burst,
                              input logic lock);
    sel_op[p]      = 1'b1;
    held_op[p]     = 1'b1;
    trans_op[p]    = trans;
    burst_op[p]    = burst;
    mastlock_op[p] = lock;
    write_op[p]    = 1'b1;
    size_op[p]     = 3'b010;                   // Word
    addr_op[p]     = {$urandom} & 32'hffff_fffc;
    wdata_op[p]    = $urandom;
  endtask

  task automatic next_beat(input int p);
    trans_op[p] = `HTRANS_SEQ;
    addr_op[p]  = addr_op[p] + 4;
  endtask

  // Address and write data kept for a pending data phase
  task automatic release_port(input int p, input logic lock);
    sel_op[p]      = 1'b0;
    held_op[p]     = 1'b0;
    trans_op[p]    = `HTRANS_IDLE;
    mastlock_op[p] = lock;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge HCLK);
  endtask

  task automatic wait_for_grant(input int p);
    int n;
    n = 0;
    @(negedge HCLK);
    while (o_active_op != (`NUM_PORTS'(1) << p) && n < GRANT_WAIT)
    begin
      @(negedge HCLK);
      n++;
    end
    if (o_active_op != (`NUM_PORTS'(1) << p))
      report_problem($sformatf("port %0d not granted within %0d cycles", p, GRANT_WAIT));
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    err_start = err_count;
  endtask

  task automatic end_test();
    tests_run++;
    $display("Test %s done, %0d errors", cur_test, err_count - err_start);
  endtask

  // Tests --------------------
  task automatic single_transfer_test();
    begin_test("single_pass_through");
    request_port(1, `HTRANS_NONSEQ, `HBURST_SINGLE, 1'b0);
    wait_for_grant(1);
    assert (o_haddrm == addr_op[1]) else report_mismatch("haddr", addr_op[1], o_haddrm);
    assert (o_hwritem == write_op[1]) else report_mismatch("hwrite", write_op[1], o_hwritem);
    assert (o_hsizem == size_op[1]) else report_mismatch("hsize", size_op[1], o_hsizem);
    @(negedge HCLK);
    release_port(1, 1'b0);
    idle_cycles(3);
    end_test();
  endtask

  task automatic priority_test();
    begin_test("priority");
    for (int p = 0; p < `NUM_PORTS; p++)
      request_port(p, `HTRANS_NONSEQ, `HBURST_SINGLE, 1'b0);
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      wait_for_grant(p);                       // Lowest remaining port
      @(negedge HCLK);
      release_port(p, 1'b0);
    end
    idle_cycles(3);
    end_test();
  endtask

  task automatic burst_hold_test();
    begin_test("burst_hold");
    request_port(2, `HTRANS_NONSEQ, 3'b001, 1'b0);   // INCR
    wait_for_grant(2);
    request_port(0, `HTRANS_NONSEQ, `HBURST_SINGLE, 1'b0);
    repeat (4)
    begin
      @(negedge HCLK);
      assert (o_active_op == 4'b0100) else report_mismatch("burst owner", 4'b0100, o_active_op);
      next_beat(2);
    end
    @(negedge HCLK);
    release_port(2, 1'b0);
    wait_for_grant(0);
    @(negedge HCLK);
    release_port(0, 1'b0);
    idle_cycles(3);
    end_test();
  endtask

  task automatic locked_sequence_test();
    begin_test("locked_sequence");
    request_port(3, `HTRANS_NONSEQ, `HBURST_SINGLE, 1'b1);
    wait_for_grant(3);
    @(negedge HCLK);
    release_port(3, 1'b1);                     // HSEL off, lock kept
    request_port(0, `HTRANS_NONSEQ, `HBURST_SINGLE, 1'b0);
    repeat (4)
    begin
      @(negedge HCLK);
      assert (o_active_op == 4'b1000) else report_mismatch("lock owner", 4'b1000, o_active_op);
    end
    release_port(3, 1'b0);
    wait_for_grant(0);
    @(negedge HCLK);
    release_port(0, 1'b0);
    idle_cycles(3);
    end_test();
  endtask

  task automatic write_wait_test();
    int p;
    int waits;
    begin_test("write_data_wait_states");
    repeat (WRITE_BEATS)
    begin
      p     = $urandom_range(`NUM_PORTS - 1, 0);
      waits = $urandom_range(MAX_WAITS, 0);
      request_port(p, `HTRANS_NONSEQ, `HBURST_SINGLE, 1'b0);
      wait_for_grant(p);
      assert (o_haddrm == addr_op[p]) else report_mismatch("haddr", addr_op[p], o_haddrm);
      @(negedge HCLK);                         // Address phase done
      assert (o_hwdatam == wdata_op[p]) else report_mismatch("hwdata", wdata_op[p], o_hwdatam);
      release_port(p, 1'b0);
      i_hreadyoutm = (waits == 0);
      for (int k = 0; k < waits; k++)
      begin
        @(negedge HCLK);
        assert (o_hreadymuxm == 1'b0) else report_mismatch("hready low", 0, o_hreadymuxm);
        assert (o_hwdatam == wdata_op[p]) else report_mismatch("hwdata", wdata_op[p], o_hwdatam);
        if (k == waits - 1)
          i_hreadyoutm = 1'b1;                 // Target ends the wait
      end
      @(negedge HCLK);
      assert (o_hwdatam == '0) else report_mismatch("hwdata idle", 0, o_hwdatam);
    end
    end_test();
  endtask

  // Watchdog --------------------
  initial
  begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, run did not complete", WATCHDOG_NS);
    $display("Simulation finished: FAIL");
    $finish;
  end

  // Main sequence --------------------
  initial
  begin
    HRESETn      = 1'b0;
    sel_op       = '0;
    addr_op      = '0;
    trans_op     = '0;
    write_op     = '0;
    size_op      = '0;
    burst_op     = '0;
    mastlock_op  = '0;
    wdata_op     = '0;
    held_op      = '0;
    i_hreadyoutm = 1'b1;
    void'($urandom(35));
    repeat (2) @(negedge HCLK);                // Two reset edges
    HRESETn = 1'b1;

    begin_test("reset_state");
    assert (o_active_op == '0) else report_mismatch("active", 0, o_active_op);
    assert (o_hselm == 1'b0) else report_mismatch("hsel", 0, o_hselm);
    assert (o_htransm == `HTRANS_IDLE) else report_mismatch("htrans", 0, o_htransm);
    assert (o_hwdatam == '0) else report_mismatch("hwdata", 0, o_hwdatam);
    assert (o_hreadymuxm == 1'b1) else report_mismatch("hready", 1, o_hreadymuxm);
    idle_cycles(2);
    end_test();

    single_transfer_test();
    priority_test();
    burst_hold_test();
    locked_sequence_test();
    write_wait_test();

    $display("Summary: %0d tests run, %0d checks failed", tests_run, err_count);
    if (err_count == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule
